//--- Makefile
TOOL      := verilator
TOP       := tb_isp
FILELIST  := project.f
FLAGS     := --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
source/isp_pkg.sv
source/isp_ctrl.sv
source/axi_read_master.sv
source/exposure_scaler.sv
source/axi_write_master.sv
source/brightness_accum.sv
source/isp_top.sv
test/tb_clock_gen.sv
test/dram_model.sv
test/isp_props.sv
test/tb_isp.sv

//--- source/axi_read_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [isp_pkg::pic_w-1:0]   pic_no,
    input  logic                        arready,
    input  logic                        rvalid,
    input  logic [isp_pkg::data_w-1:0]  rdata,
    input  logic                        rlast,
    input  logic                        buf_free,
    output logic                        arvalid,
    output logic [isp_pkg::addr_w-1:0]  araddr,
    output logic                        rready,
    output logic                        beat_take,
    output logic [isp_pkg::data_w-1:0]  beat_data
);
    import isp_pkg::*;

    logic r_open;

    // no new beat unless the buffer can take it
    assign rready    = r_open && buf_free;
    assign beat_take = rvalid && rready;
    assign beat_data = rdata;

    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= pic_base + addr_w'(pic_no) * pic_bytes;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            r_open  <= 1'b0;
        end else begin
            if (start) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                r_open <= 1'b1;
            end else if (beat_take && rlast) begin
                r_open <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/axi_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [isp_pkg::pic_w-1:0]   pic_no,
    input  logic                        awready,
    input  logic                        buf_full,
    input  logic [isp_pkg::data_w-1:0]  buf_data,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        awvalid,
    output logic [isp_pkg::addr_w-1:0]  awaddr,
    output logic                        wvalid,
    output logic [isp_pkg::data_w-1:0]  wdata,
    output logic                        wlast,
    output logic                        bready,
    output logic                        beat_sent,
    output logic                        write_done
);
    import isp_pkg::*;

    logic                  w_open;
    logic                  last_beat;
    logic [beat_cnt_w-1:0] beat_cnt;

    // the buffer holds its beat until sent, so wdata stays put under stalls
    assign wvalid     = w_open && buf_full;
    assign wdata      = buf_data;
    assign last_beat  = (beat_cnt == beat_cnt_w'(burst_beats - 1));
    assign wlast      = wvalid && last_beat;
    assign beat_sent  = wvalid && wready;
    assign write_done = bvalid && bready;

    always_ff @(posedge clk) begin
        if (start) begin
            awaddr <= pic_base + addr_w'(pic_no) * pic_bytes;
        end
    end

    // ----------------------------------------
    // AW, W and B sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awvalid  <= 1'b0;
            w_open   <= 1'b0;
            bready   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (start) begin
                awvalid <= 1'b1;
            end else if (awready) begin
                awvalid <= 1'b0;
            end
            if (start) begin
                beat_cnt <= '0;
            end else if (beat_sent) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (awvalid && awready) begin
                w_open <= 1'b1;
            end else if (beat_sent && last_beat) begin
                w_open <= 1'b0;
            end
            if (beat_sent && last_beat) begin
                bready <= 1'b1;
            end else if (bvalid) begin
                bready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/brightness_accum.sv
`timescale 1ns/10ps
`default_nettype none

module brightness_accum (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        beat_sent,
    input  logic [isp_pkg::data_w-1:0]  buf_data,
    output logic                        bright_valid,
    output logic [isp_pkg::pix_w-1:0]   brightness
);
    import isp_pkg::*;

    logic [beat_cnt_w-1:0] beat_cnt;
    logic                  g_plane;
    logic                  last_beat;
    logic [pix_w-1:0]      wt [beat_pix];
    logic [pix_w:0]        s1 [beat_pix/2];
    logic [pix_w+1:0]      s2 [beat_pix/4];
    logic [pix_w+2:0]      s3 [beat_pix/8];
    logic [2:0]            v;
    logic [2:0]            l;
    logic [sum_w-1:0]      sum;

    assign g_plane   = (beat_cnt >= color_beats) && (beat_cnt < 2 * color_beats);
    assign last_beat = (beat_cnt == beat_cnt_w'(burst_beats - 1));
    assign brightness = sum[sum_w-1:bright_shift];

    // green counts half, red and blue a quarter each
    always_comb begin
        for (int i = 0; i < beat_pix; i++) begin
            if (g_plane) begin
                wt[i] = buf_data[i*pix_w +: pix_w] >> 1;
            end else begin
                wt[i] = buf_data[i*pix_w +: pix_w] >> 2;
            end
        end
    end

    // ----------------------------------------
    // adder tree, one beat per stage
    always_ff @(posedge clk) begin
        for (int i = 0; i < beat_pix / 2; i++) begin
            s1[i] <= wt[2*i] + wt[2*i+1];
        end
        for (int i = 0; i < beat_pix / 4; i++) begin
            s2[i] <= s1[2*i] + s1[2*i+1];
        end
        for (int i = 0; i < beat_pix / 8; i++) begin
            s3[i] <= s2[2*i] + s2[2*i+1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt     <= '0;
            v            <= '0;
            l            <= '0;
            sum          <= '0;
            bright_valid <= 1'b0;
        end else begin
            v            <= {v[1:0], beat_sent};
            l            <= {l[1:0], beat_sent && last_beat};
            bright_valid <= v[2] && l[2];
            if (start) begin
                beat_cnt <= '0;
            end else if (beat_sent) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            // start comes well before the first beat reaches the sum
            if (start) begin
                sum <= '0;
            end else if (v[2]) begin
                sum <= sum + sum_w'(s3[0]) + sum_w'(s3[1]);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/exposure_scaler.sv
`timescale 1ns/10ps
`default_nettype none

module exposure_scaler (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [isp_pkg::ratio_w-1:0]  ratio,
    input  logic                         beat_take,
    input  logic [isp_pkg::data_w-1:0]   beat_data,
    input  logic                         beat_sent,
    output logic [isp_pkg::data_w-1:0]   buf_data,
    output logic                         buf_full,
    output logic                         buf_free
);
    import isp_pkg::*;

    logic [data_w-1:0] scaled;

    // a beat leaving this cycle frees the slot for the next one
    assign buf_free = !buf_full || beat_sent;

    always_comb begin
        for (int i = 0; i < beat_pix; i++) begin
            case (ratio)
                ratio_quarter: scaled[i*pix_w +: pix_w] = beat_data[i*pix_w +: pix_w] >> 2;
                ratio_half:    scaled[i*pix_w +: pix_w] = beat_data[i*pix_w +: pix_w] >> 1;
                ratio_unity:   scaled[i*pix_w +: pix_w] = beat_data[i*pix_w +: pix_w];
                ratio_double: begin
                    // top bit set means the double overflows
                    if (beat_data[i*pix_w + pix_w - 1]) begin
                        scaled[i*pix_w +: pix_w] = {pix_w{1'b1}};
                    end else begin
                        scaled[i*pix_w +: pix_w] = {beat_data[i*pix_w +: pix_w-1], 1'b0};
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            buf_data <= scaled;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
        end else if (beat_take) begin
            buf_full <= 1'b1;
        end else if (beat_sent) begin
            buf_full <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/isp_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module isp_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [isp_pkg::pic_w-1:0]    in_pic_no,
    input  logic [isp_pkg::ratio_w-1:0]  in_ratio_mode,
    input  logic                         write_done,
    input  logic                         bright_valid,
    input  logic [isp_pkg::pix_w-1:0]    brightness,
    output logic                         start,
    output logic [isp_pkg::pic_w-1:0]    pic_no,
    output logic [isp_pkg::ratio_w-1:0]  ratio,
    output logic                         out_valid,
    output logic [isp_pkg::pix_w-1:0]    out_data
);
    import isp_pkg::*;

    logic                look;
    logic                busy;
    logic                w_seen;
    logic                b_seen;
    logic                hit;
    logic                finish;
    logic [num_pics-1:0] recorded;
    logic [pix_w-1:0]    bright_mem [num_pics];

    // ratio 2 leaves the image as it is, so a recorded result still holds
    assign hit    = recorded[pic_no] && (ratio == ratio_unity);
    assign finish = busy && (w_seen || write_done) && (b_seen || bright_valid);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pic_no <= in_pic_no;
            ratio  <= in_ratio_mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            look      <= 1'b0;
            busy      <= 1'b0;
            start     <= 1'b0;
            w_seen    <= 1'b0;
            b_seen    <= 1'b0;
            out_valid <= 1'b0;
            recorded  <= '0;
        end else begin
            look      <= in_valid;
            start     <= look && !hit;
            out_valid <= (look && hit) || finish;
            if (look && !hit) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
            // both ends of the pass may finish in either order
            if (finish) begin
                w_seen <= 1'b0;
                b_seen <= 1'b0;
            end else begin
                w_seen <= w_seen || write_done;
                b_seen <= b_seen || bright_valid;
            end
            if (finish) begin
                recorded[pic_no] <= 1'b1;
            end
        end
    end

    // result cache and output word
    always_ff @(posedge clk) begin
        if (finish) begin
            bright_mem[pic_no] <= brightness;
            out_data           <= brightness;
        end else if (look && hit) begin
            out_data <= bright_mem[pic_no];
        end
    end

endmodule

`default_nettype wire

//--- source/isp_pkg.sv
`default_nettype none

package isp_pkg;

    // ----------------------------------------
    // data path
    localparam int data_w   = 128;
    localparam int pix_w    = 8;
    localparam int beat_pix = 16;

    // ----------------------------------------
    // picture layout in DRAM
    localparam int addr_w      = 32;
    localparam int pic_w       = 4;
    localparam int num_pics    = 16;
    localparam int burst_beats = 192;
    localparam int color_beats = 64;
    localparam int beat_cnt_w  = 8;
    localparam logic [addr_w-1:0] pic_base = 32'h0001_0000;
    localparam int pic_bytes   = 3072;

    // fixed AXI burst fields
    localparam logic [beat_cnt_w-1:0] axi_len        = 8'd191;
    localparam logic [2:0]            axi_size       = 3'd4;
    localparam logic [1:0]            axi_burst_incr = 2'd1;

    // ----------------------------------------
    // exposure ratio codes
    localparam int ratio_w = 2;
    localparam logic [ratio_w-1:0] ratio_quarter = 2'd0;
    localparam logic [ratio_w-1:0] ratio_half    = 2'd1;
    localparam logic [ratio_w-1:0] ratio_unity   = 2'd2;
    localparam logic [ratio_w-1:0] ratio_double  = 2'd3;

    // brightness = sum / 1024
    localparam int sum_w        = 18;
    localparam int bright_shift = 10;

endpackage

`default_nettype wire

//--- source/isp_top.sv
`timescale 1ns/10ps
`default_nettype none

module isp_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [isp_pkg::pic_w-1:0]          in_pic_no,
    input  logic [isp_pkg::ratio_w-1:0]        in_ratio_mode,
    output logic                               out_valid,
    output logic [isp_pkg::pix_w-1:0]          out_data,
    // ----------------------------------------
    // write address
    output logic [3:0]                         awid_s_inf,
    output logic [isp_pkg::addr_w-1:0]         awaddr_s_inf,
    output logic [2:0]                         awsize_s_inf,
    output logic [1:0]                         awburst_s_inf,
    output logic [isp_pkg::beat_cnt_w-1:0]     awlen_s_inf,
    output logic                               awvalid_s_inf,
    input  logic                               awready_s_inf,
    // write data and response
    output logic [isp_pkg::data_w-1:0]         wdata_s_inf,
    output logic                               wlast_s_inf,
    output logic                               wvalid_s_inf,
    input  logic                               wready_s_inf,
    input  logic [3:0]                         bid_s_inf,
    input  logic [1:0]                         bresp_s_inf,
    input  logic                               bvalid_s_inf,
    output logic                               bready_s_inf,
    // ----------------------------------------
    // read address and data
    output logic [3:0]                         arid_s_inf,
    output logic [isp_pkg::addr_w-1:0]         araddr_s_inf,
    output logic [isp_pkg::beat_cnt_w-1:0]     arlen_s_inf,
    output logic [2:0]                         arsize_s_inf,
    output logic [1:0]                         arburst_s_inf,
    output logic                               arvalid_s_inf,
    input  logic                               arready_s_inf,
    input  logic [3:0]                         rid_s_inf,
    input  logic [isp_pkg::data_w-1:0]         rdata_s_inf,
    input  logic [1:0]                         rresp_s_inf,
    input  logic                               rlast_s_inf,
    input  logic                               rvalid_s_inf,
    output logic                               rready_s_inf
);

    logic                           start;
    logic [isp_pkg::pic_w-1:0]      pic_no;
    logic [isp_pkg::ratio_w-1:0]    ratio;
    logic                           beat_take;
    logic [isp_pkg::data_w-1:0]     beat_data;
    logic [isp_pkg::data_w-1:0]     buf_data;
    logic                           buf_full;
    logic                           buf_free;
    logic                           beat_sent;
    logic                           write_done;
    logic                           bright_valid;
    logic [isp_pkg::pix_w-1:0]      brightness;

    // every burst is one whole picture
    assign awid_s_inf    = 4'd0;
    assign awlen_s_inf   = isp_pkg::axi_len;
    assign awsize_s_inf  = isp_pkg::axi_size;
    assign awburst_s_inf = isp_pkg::axi_burst_incr;
    assign arid_s_inf    = 4'd0;
    assign arlen_s_inf   = isp_pkg::axi_len;
    assign arsize_s_inf  = isp_pkg::axi_size;
    assign arburst_s_inf = isp_pkg::axi_burst_incr;

    isp_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_pic_no(in_pic_no),
        .in_ratio_mode(in_ratio_mode), .write_done(write_done),
        .bright_valid(bright_valid), .brightness(brightness), .start(start),
        .pic_no(pic_no), .ratio(ratio), .out_valid(out_valid), .out_data(out_data)
    );

    axi_read_master u_rd (
        .clk(clk), .rst_n(rst_n), .start(start), .pic_no(pic_no),
        .arready(arready_s_inf), .rvalid(rvalid_s_inf), .rdata(rdata_s_inf),
        .rlast(rlast_s_inf), .buf_free(buf_free), .arvalid(arvalid_s_inf),
        .araddr(araddr_s_inf), .rready(rready_s_inf), .beat_take(beat_take),
        .beat_data(beat_data)
    );

    exposure_scaler u_scale (
        .clk(clk), .rst_n(rst_n), .ratio(ratio), .beat_take(beat_take),
        .beat_data(beat_data), .beat_sent(beat_sent), .buf_data(buf_data),
        .buf_full(buf_full), .buf_free(buf_free)
    );

    axi_write_master u_wr (
        .clk(clk), .rst_n(rst_n), .start(start), .pic_no(pic_no),
        .awready(awready_s_inf), .buf_full(buf_full), .buf_data(buf_data),
        .wready(wready_s_inf), .bvalid(bvalid_s_inf), .awvalid(awvalid_s_inf),
        .awaddr(awaddr_s_inf), .wvalid(wvalid_s_inf), .wdata(wdata_s_inf),
        .wlast(wlast_s_inf), .bready(bready_s_inf), .beat_sent(beat_sent),
        .write_done(write_done)
    );

    brightness_accum u_bright (
        .clk(clk), .rst_n(rst_n), .start(start), .beat_sent(beat_sent),
        .buf_data(buf_data), .bright_valid(bright_valid), .brightness(brightness)
    );

endmodule

`default_nettype wire

//--- test/dram_model.sv
`timescale 1ns/10ps
`default_nettype none

module dram_model #(
    parameter logic [15:0] seed      = 16'd1,
    parameter int          stall_num = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  araddr,
    input  logic         arvalid,
    output logic         arready,
    output logic [127:0] rdata,
    output logic         rlast,
    output logic         rvalid,
    input  logic         rready,
    input  logic [31:0]  awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  logic [127:0] wdata,
    input  logic         wlast,
    input  logic         wvalid,
    output logic         wready,
    output logic         bvalid,
    input  logic         bready
);

    localparam int base_addr = 'h10000;
    localparam int num_beats = 16 * 192;

    logic [127:0] mem [num_beats];
    logic [15:0]  lfsr;
    int           rd_ptr;
    int           rd_left;
    int           wr_ptr;
    bit           wr_open;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [127:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[126:0], lfsr[0]};
        end
    endtask

    // stall_num chances out of 8
    task automatic draw_stall(output bit s);
        logic [127:0] val;
        draw_bits(3, val);
        s = (val < stall_num);
    endtask

    initial begin
        logic [127:0] word;
        lfsr = seed;
        for (int b = 0; b < num_beats; b++) begin
            draw_bits(128, word);
            mem[b] = word;
        end
    end

    always @(posedge clk or negedge rst_n) begin : slave
        bit s;
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rd_left = 0;
            wr_open = 1'b0;
        end else begin
            // ----------------------------------------
            // read side
            if (arvalid && arready) begin
                rd_ptr  = (araddr - base_addr) / 16;
                rd_left = 192;
                arready <= 1'b0;
            end else begin
                draw_stall(s);
                arready <= (rd_left == 0) && !s;
            end
            if (rvalid && rready) begin
                rd_ptr  = rd_ptr + 1;
                rd_left = rd_left - 1;
            end
            // a presented beat stays until taken
            if (!rvalid || rready) begin
                draw_stall(s);
                if (rd_left > 0 && !s) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_ptr];
                    rlast  <= (rd_left == 1);
                end else begin
                    rvalid <= 1'b0;
                    rlast  <= 1'b0;
                end
            end
            // ----------------------------------------
            // write side
            if (awvalid && awready) begin
                wr_ptr  = (awaddr - base_addr) / 16;
                wr_open = 1'b1;
                awready <= 1'b0;
            end else begin
                draw_stall(s);
                awready <= !wr_open && !bvalid && !s;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                mem[wr_ptr] = wdata;
                wr_ptr = wr_ptr + 1;
                if (wlast) begin
                    wr_open = 1'b0;
                    bvalid <= 1'b1;
                end
            end
            draw_stall(s);
            wready <= wr_open && !s;
        end
    end

endmodule

`default_nettype wire

//--- test/isp_props.sv
`timescale 1ns/10ps
`default_nettype none

module isp_props (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        in_valid,
    input logic                        out_valid,
    input logic                        arvalid,
    input logic                        arready,
    input logic                        rready,
    input logic                        awvalid,
    input logic                        awready,
    input logic                        wvalid,
    input logic                        wready,
    input logic [isp_pkg::data_w-1:0]  wdata,
    input logic                        bready
);

    int   fail_cnt = 0;
    logic seen_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_req <= 1'b0;
        end else if (in_valid) begin
            seen_req <= 1'b1;
        end
    end

    // ----------------------------------------
    // bus quiet until the first request
    quiet_before_request: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> !(arvalid || rready || awvalid || wvalid || bready || out_valid))
    else begin
        fail_cnt++;
        $error("bus or result active before the first request");
    end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
    else begin
        fail_cnt++;
        $error("write beat dropped or changed while stalled");
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
    else begin
        fail_cnt++;
        $error("arvalid dropped before arready");
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
    else begin
        fail_cnt++;
        $error("awvalid dropped before awready");
    end

    // result is a single-cycle pulse
    out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
    else begin
        fail_cnt++;
        $error("out_valid high for two cycles in a row");
    end

endmodule

bind isp_top isp_props u_props (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
    .arvalid(arvalid_s_inf), .arready(arready_s_inf), .rready(rready_s_inf),
    .awvalid(awvalid_s_inf), .awready(awready_s_inf), .wvalid(wvalid_s_inf),
    .wready(wready_s_inf), .wdata(wdata_s_inf), .bready(bready_s_inf)
);

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int period       = 10,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_isp.sv
`timescale 1ns/10ps
`default_nettype none

module tb_isp;
    import isp_pkg::*;

    localparam logic [15:0] lfsr_seed    = 16'd2312;
    localparam int          stall_num    = 2;
    localparam int          reset_limit  = 20;
    localparam int          result_limit = 5000;
    localparam int          mem_base     = 'h10000;
    localparam int          beats        = 192;
    localparam int          n_req        = 9;

    logic clk, rst_n, in_valid, out_valid;
    logic [pic_w-1:0]      in_pic_no;
    logic [ratio_w-1:0]    in_ratio_mode;
    logic [pix_w-1:0]      out_data;
    logic [3:0]            awid, bid, arid, rid;
    logic [addr_w-1:0]     awaddr, araddr;
    logic [2:0]            awsize, arsize;
    logic [1:0]            awburst, arburst, bresp, rresp;
    logic [beat_cnt_w-1:0] awlen, arlen;
    logic                  awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rlast, rvalid, rready;
    logic [data_w-1:0]     wdata, rdata;

    int           errors = 0;
    int           timeouts = 0;
    int           ar_hs, aw_hs, w_beats, cur_pic;
    bit           recorded [16];
    int           stored [16];
    logic [127:0] img [beats];
    logic [127:0] exp_img [beats];
    int           req_pic [n_req]   = '{0, 1, 2, 3, 3, 0, 2, 2, 1};
    int           req_ratio [n_req] = '{0, 1, 3, 2, 2, 2, 3, 2, 2};

    assign bid   = '0;
    assign bresp = '0;
    assign rid   = '0;
    assign rresp = '0;

    tb_clock_gen #(.period(10), .reset_cycles(2)) u_clk (.clk(clk), .rst_n(rst_n));

    dram_model #(.seed(lfsr_seed), .stall_num(stall_num)) u_dram (
        .clk(clk), .rst_n(rst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
        .wlast(wlast), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    isp_top UUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_pic_no(in_pic_no),
        .in_ratio_mode(in_ratio_mode), .out_valid(out_valid), .out_data(out_data),
        .awid_s_inf(awid), .awaddr_s_inf(awaddr), .awsize_s_inf(awsize),
        .awburst_s_inf(awburst), .awlen_s_inf(awlen), .awvalid_s_inf(awvalid),
        .awready_s_inf(awready), .wdata_s_inf(wdata), .wlast_s_inf(wlast),
        .wvalid_s_inf(wvalid), .wready_s_inf(wready), .bid_s_inf(bid),
        .bresp_s_inf(bresp), .bvalid_s_inf(bvalid), .bready_s_inf(bready),
        .arid_s_inf(arid), .araddr_s_inf(araddr), .arlen_s_inf(arlen),
        .arsize_s_inf(arsize), .arburst_s_inf(arburst), .arvalid_s_inf(arvalid),
        .arready_s_inf(arready), .rid_s_inf(rid), .rdata_s_inf(rdata),
        .rresp_s_inf(rresp), .rlast_s_inf(rlast), .rvalid_s_inf(rvalid),
        .rready_s_inf(rready)
    );

    // ----------------------------------------
    // reference model
    function automatic logic [7:0] scale_pix(input logic [7:0] p, input int r);
        case (r)
            0:       return 8'(p / 4);
            1:       return 8'(p / 2);
            2:       return p;
            default: return (p > 127) ? 8'd255 : 8'(p * 2);
        endcase
    endfunction

    function automatic logic [127:0] scale_beat(input logic [127:0] b, input int r);
        logic [127:0] s;
        for (int i = 0; i < 16; i++) begin
            s[i*8 +: 8] = scale_pix(b[i*8 +: 8], r);
        end
        return s;
    endfunction

    // R and B weigh a quarter, G a half
    function automatic int expected_brightness();
        int sum = 0;
        for (int b = 0; b < beats; b++) begin
            for (int i = 0; i < 16; i++) begin
                sum += (b / 64 == 1) ? exp_img[b][i*8 +: 8] / 2 : exp_img[b][i*8 +: 8] / 4;
            end
        end
        return sum / 1024;
    endfunction

    function automatic int exp_addr(input int pic);
        return mem_base + pic * beats * 16;
    endfunction

    task automatic check_value(input string name, input longint got, input longint expected);
        assert (got == expected) else begin
            errors++;
            $display("error at %0t: %s = 'h%0h, expected 'h%0h", $time, name, got, expected);
        end
    endtask

    task automatic run_request(input int pic, input int ratio, output int cycles);
        @(posedge clk);
        in_valid      <= 1'b1;
        in_pic_no     <= pic_w'(pic);
        in_ratio_mode <= ratio_w'(ratio);
        cycles = 0;
        do begin
            @(posedge clk);
            in_valid <= 1'b0;
            cycles++;
            @(negedge clk);
        end while (!out_valid && cycles < result_limit);
    endtask

    // bus monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (arvalid && arready) begin
            ar_hs++;
            check_value("araddr", araddr, exp_addr(cur_pic));
            // id 0, 192 beats of 16 bytes, incrementing
            check_value("arid", arid, 0);
            check_value("arlen", arlen, beats - 1);
            check_value("arsize", arsize, 4);
            check_value("arburst", arburst, 1);
        end
        if (awvalid && awready) begin
            aw_hs++;
            w_beats = 0;
            check_value("awaddr", awaddr, exp_addr(cur_pic));
            check_value("awid", awid, 0);
            check_value("awlen", awlen, beats - 1);
            check_value("awsize", awsize, 4);
            check_value("awburst", awburst, 1);
        end
        if (wvalid && wready) begin
            check_value("wlast", wlast, w_beats == beats - 1);
            w_beats++;
        end
    end

    // ----------------------------------------
    // request sequence
    initial begin
        int  cycles;
        int  waited;
        int  pic;
        int  ratio;
        int  prop_fails;
        bit  hit;
        in_valid      = 1'b0;
        in_pic_no     = '0;
        in_ratio_mode = '0;
        waited = 0;
        while (!rst_n && waited < reset_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("reset was never released");
        end
        for (int n = 0; n < n_req && timeouts == 0; n++) begin
            pic     = req_pic[n];
            ratio   = req_ratio[n];
            hit     = recorded[pic] && ratio == 2;
            cur_pic = pic;
            ar_hs   = 0;
            aw_hs   = 0;
            for (int b = 0; b < beats; b++) begin
                img[b] = u_dram.mem[pic * beats + b];
            end
            run_request(pic, ratio, cycles);
            if (!out_valid) begin
                timeouts++;
                $display("no result for picture %0d within %0d cycles", pic, result_limit);
            end else if (hit) begin
                check_value("out_valid latency", cycles, 2);
                check_value("ar handshakes", ar_hs, 0);
                check_value("aw handshakes", aw_hs, 0);
                check_value("out_data", out_data, stored[pic]);
            end else begin
                for (int b = 0; b < beats; b++) begin
                    exp_img[b] = scale_beat(img[b], ratio);
                    assert (u_dram.mem[pic * beats + b] === exp_img[b]) else begin
                        errors++;
                        $display("error at %0t: dram beat %0d = %h, expected %h", $time, b,
                                 u_dram.mem[pic * beats + b], exp_img[b]);
                    end
                end
                stored[pic]   = expected_brightness();
                recorded[pic] = 1'b1;
                check_value("ar handshakes", ar_hs, 1);
                check_value("aw handshakes", aw_hs, 1);
                check_value("out_data", out_data, stored[pic]);
            end
        end
        // let the last properties settle
        repeat (4) @(posedge clk);
        prop_fails = UUT.u_props.fail_cnt;
        $display("errors: %0d value, %0d property, %0d timeout", errors, prop_fails, timeouts);
        if (errors == 0 && prop_fails == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
